// ==== hw/dfpSqrtCollect.sv ====
// drains the finishing lane and packs the registered result word of the square-root unit
`timescale 1ns/100ps
`default_nettype none

module dfpSqrtCollect (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic [dfpSqrtPkg::NUM_LANES-1:0] laneDone,
	input  logic [23:0]                      laneRoot [dfpSqrtPkg::NUM_LANES],
	input  logic [6:0]                       laneExp [dfpSqrtPkg::NUM_LANES],
	input  dfpSqrtPkg::sqrtClass             laneClass [dfpSqrtPkg::NUM_LANES],
	output logic                             outValid,
	output dfpSqrtPkg::dfpWord               outData
);
	import dfpSqrtPkg::*;

	logic [23:0] selRoot;
	logic [6:0] selExp;
	sqrtClass selClass;
	dfpWord packedWord;

	// ------------------------------------------------------------------
	// lane select with at most one done per cycle
	// ------------------------------------------------------------------
	always_comb
	begin
		selRoot = '0;
		selExp = '0;
		selClass = classFinite;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (laneDone[i])
			begin
				selRoot = laneRoot[i];
				selExp = laneExp[i];
				selClass = laneClass[i];
			end
		end
	end

	// pack by class
	always_comb
	begin
		packedWord.sign = 1'b0;
		packedWord.exp = EXP_ONES;
		packedWord.sig = INVALID_SIG;
		case (selClass)
			classFinite:
			begin
				packedWord.exp = selExp;
				packedWord.sig = selRoot;
			end
			classZero:
			begin
				// original zero with its sign back in root bit 23
				packedWord.sign = selRoot[23];
				packedWord.exp = selExp;
				packedWord.sig = '0;
			end
			classNan:
			begin
				packedWord.sign = selExp[0];
				packedWord.sig = selRoot;
			end
			classPosInf:
				packedWord.sig = '0;
			default:
				packedWord.sig = INVALID_SIG;
		endcase
	end

	// ------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= |laneDone;
	end

	always_ff @(posedge clk)
	begin
		if (|laneDone)
			outData <= packedWord;
	end

	// one-hot starts and a fixed lane latency keep completions apart
	aDoneOneHot: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0(laneDone));

endmodule

`default_nettype wire

// ==== hw/dfpSqrtDispatch.sv ====
// operand decode and round-robin lane issue for the decimal square-root unit
`timescale 1ns/100ps
`default_nettype none

module dfpSqrtDispatch (
	input  logic                               clk,
	input  logic                               rstN,
	input  logic                               inValid,
	input  dfpSqrtPkg::dfpWord                 inData,
	output logic [dfpSqrtPkg::NUM_LANES-1:0]   startLane,
	output logic [47:0]                        radicand,
	output logic [6:0]                         resExp,
	output dfpSqrtPkg::sqrtClass               resClass,
	input  logic [dfpSqrtPkg::NUM_LANES-1:0]   laneBusy
);
	import dfpSqrtPkg::*;

	// round-robin pointer over the lanes
	logic [$clog2(NUM_LANES)-1:0] ptr;

	// decoded values before the issue register
	sqrtClass nextClass;
	logic [47:0] nextRad;
	logic [6:0] nextExp;
	logic signed [8:0] expUnb;
	logic signed [8:0] expHalf;

	// ------------------------------------------------------------------
	// classify and build radicand / exponent
	// ------------------------------------------------------------------
	always_comb
	begin
		// unbiased exponent, then floor((e - 5) / 2) via arithmetic shift
		expUnb = $signed({2'b00, inData.exp}) - $signed({2'b00, EXP_BIAS});
		expHalf = (expUnb - 9'sd5) >>> 1;

		if (inData.exp == EXP_ONES)
		begin
			if (inData.sig != '0)
				nextClass = classNan;
			else if (inData.sign)
				nextClass = classInvalid;
			else
				nextClass = classPosInf;
		end
		else if (inData.sig == '0)
			nextClass = classZero;
		else if (inData.sign)
			nextClass = classInvalid;
		else
			nextClass = classFinite;

		nextRad = '0;
		nextExp = EXP_ONES;
		case (nextClass)
			classFinite:
			begin
				// even exponent shifts six digits, odd shifts five
				if (!expUnb[0])
					nextRad = {inData.sig, 24'h0};
				else
					nextRad = {4'h0, inData.sig, 20'h0};
				nextExp = expHalf[6:0] + EXP_BIAS;
			end
			classZero:
			begin
				// sign rides in the top radicand bit, exponent kept as is
				nextRad = {inData.sign, 47'h0};
				nextExp = inData.exp;
			end
			classNan:
			begin
				// payload in the low digits, sign in exponent bit 0
				nextRad = {24'h0, inData.sig};
				nextExp = {6'h00, inData.sign};
			end
			default:
			begin
				nextRad = '0;
				nextExp = EXP_ONES;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// issue register
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			startLane <= '0;
			ptr <= '0;
		end
		else
		begin
			startLane <= '0;
			if (inValid)
			begin
				startLane <= NUM_LANES'(1) << ptr;
				if (ptr == NUM_LANES - 1)
					ptr <= '0;
				else
					ptr <= ptr + 1'b1;
			end
		end
	end

	// shared lane inputs, sampled only on the lane's start strobe
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			radicand <= nextRad;
			resExp <= nextExp;
			resClass <= nextClass;
		end
	end

	// issue spacing must leave the chosen lane idle
	aStartIdle: assert property (@(posedge clk) disable iff (!rstN)
		!(|(startLane & laneBusy)));

endmodule

`default_nettype wire

// ==== hw/dfpSqrtLane.sv ====
// one digit-by-digit decimal square-root engine with fixed latency, instanced per lane in the top
`timescale 1ns/100ps
`default_nettype none

module dfpSqrtLane (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 start,
	input  logic [47:0]          radicand,
	input  logic [6:0]           resExp,
	input  dfpSqrtPkg::sqrtClass resClass,
	output logic                 busy,
	output logic                 done,
	output logic [23:0]          root,
	output logic [6:0]           rootExp,
	output dfpSqrtPkg::sqrtClass rootClass
);
	import dfpSqrtPkg::*;

	// control state
	logic running;
	logic [2:0] digitIdx;
	// step 0 brings down digits, steps 1..9 are trials
	logic [3:0] step;

	// datapath
	logic [47:0] radReg;
	logic [47:0] remReg;
	logic [23:0] rootReg;
	logic [6:0] expReg;
	sqrtClass classReg;

	logic [47:0] trial;
	logic [23:0] sideInfo;

	// subtrahend from the root so far and the digit being built
	assign trial = bcdTimesTwentyPlus({4'h0, rootReg[23:4]}, rootReg[3:0]);

	// non-finite results pass straight through; zero sign folded into bit 23
	assign sideInfo = radicand[23:0] | {radicand[47], 23'h0};

	// ------------------------------------------------------------------
	// sequencer stepping SIG_DIGITS phases of ten cycles
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			done <= 1'b0;
			digitIdx <= '0;
			step <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				digitIdx <= '0;
				step <= '0;
			end
			else if (running)
			begin
				if (step == 4'd9)
				begin
					step <= '0;
					if (digitIdx == SIG_DIGITS - 1)
					begin
						running <= 1'b0;
						done <= 1'b1;
					end
					else
						digitIdx <= digitIdx + 3'd1;
				end
				else
					step <= step + 4'd1;
			end
		end
	end

	// ------------------------------------------------------------------
	// recurrence datapath
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			radReg <= radicand;
			remReg <= '0;
			rootReg <= (resClass == classFinite) ? 24'h0 : sideInfo;
			expReg <= resExp;
			classReg <= resClass;
		end
		else if (running && classReg == classFinite)
		begin
			if (step == 4'd0)
			begin
				// bring down the next digit pair, open a new root digit
				remReg <= {remReg[39:0], radReg[47:40]};
				radReg <= {radReg[39:0], 8'h00};
				rootReg <= {rootReg[19:0], 4'h0};
			end
			else if (!bcdLess(remReg, trial))
			begin
				// low digit stays below ten, so a binary increment is safe
				remReg <= bcdSub(remReg, trial);
				rootReg <= rootReg + 24'd1;
			end
		end
	end

	// busy also covers the done cycle
	assign busy = running | done;
	assign root = rootReg;
	assign rootExp = expReg;
	assign rootClass = classReg;

	aNoStartBusy: assert property (@(posedge clk) disable iff (!rstN)
		start |-> !busy);

	// fixed latency, and done drops again after one cycle
	aDoneLat: assert property (@(posedge clk) disable iff (!rstN)
		start |-> ##LANE_LAT (done ##1 !done));

endmodule

`default_nettype wire

// ==== hw/dfpSqrtPkg.sv ====
// shared fields, constants and BCD helpers that every block of the decimal square-root unit imports
`default_nettype none

package dfpSqrtPkg;

	// ------------------------------------------------------------------
	// word format of sign, 7-bit biased exponent and six BCD digits
	// ------------------------------------------------------------------
	typedef struct packed {
		logic        sign;
		logic [6:0]  exp;
		logic [23:0] sig;
	} dfpWord;

	localparam logic [6:0] EXP_BIAS = 7'd63;
	// all ones marks infinity or NaN
	localparam logic [6:0] EXP_ONES = 7'd127;
	localparam int SIG_DIGITS = 6;
	localparam int RAD_DIGITS = 12;
	// invalid NaN significand, BCD 100000
	localparam logic [23:0] INVALID_SIG = 24'h100000;

	// lane count and latencies in cycles
	localparam int NUM_LANES = 4;
	localparam int LANE_LAT  = 61;
	localparam int TOTAL_LAT = 63;
	// four lanes at this spacing cover LANE_LAT + 1
	localparam int ISSUE_GAP = 16;

	typedef enum logic [2:0] {
		classFinite,
		classZero,
		classNan,
		classPosInf,
		classInvalid
	} sqrtClass;

	// ------------------------------------------------------------------
	// BCD arithmetic on 12-digit values
	// ------------------------------------------------------------------

	// digit order matches bit order, so valid BCD compares as plain binary
	function automatic logic bcdLess(input logic [4*RAD_DIGITS-1:0] a,
		input logic [4*RAD_DIGITS-1:0] b);
		return a < b;
	endfunction

	// digit-serial subtract with borrow; caller makes sure a >= b
	function automatic logic [4*RAD_DIGITS-1:0] bcdSub(input logic [4*RAD_DIGITS-1:0] a,
		input logic [4*RAD_DIGITS-1:0] b);
		logic [4*RAD_DIGITS-1:0] diff;
		logic [4:0] d;
		logic borrow;
		borrow = 1'b0;
		for (int i = 0; i < RAD_DIGITS; i++)
		begin
			d = {1'b0, a[4*i+:4]} - {1'b0, b[4*i+:4]} - {4'd0, borrow};
			// negative digit wraps, add ten back
			if (d[4])
			begin
				d = d + 5'd10;
				borrow = 1'b1;
			end
			else
				borrow = 1'b0;
			diff[4*i+:4] = d[3:0];
		end
		return diff;
	endfunction

	// trial subtrahend 20*q + 2j + 1 from the root so far q and the current digit j
	function automatic logic [4*RAD_DIGITS-1:0] bcdTimesTwentyPlus(
		input logic [4*SIG_DIGITS-1:0] q, input logic [3:0] j);
		logic [4*RAD_DIGITS-1:0] res;
		logic [4:0] d;
		logic [4:0] odd;
		logic carry;
		res = '0;
		carry = 1'b0;
		// double q digit by digit into the next digit up, which gives 20q
		for (int i = 0; i < SIG_DIGITS; i++)
		begin
			d = {q[4*i+:4], 1'b0} + {4'd0, carry};
			if (d >= 5'd10)
			begin
				d = d - 5'd10;
				carry = 1'b1;
			end
			else
				carry = 1'b0;
			res[4*(i+1)+:4] = d[3:0];
		end
		res[4*(SIG_DIGITS+1)+:4] = {3'b000, carry};
		odd = {j, 1'b0} + 5'd1;
		// tens digit of 20q is even, so a carry of one stops there
		if (odd >= 5'd10)
		begin
			res[3:0] = 4'(odd - 5'd10);
			res[7:4] = res[7:4] + 4'd1;
		end
		else
			res[3:0] = odd[3:0];
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== hw/dfpSqrtTop.sv ====
// top level of the multi-lane decimal square-root unit holding the dispatcher, lanes and collector
`timescale 1ns/100ps
`default_nettype none

module dfpSqrtTop (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inValid,
	input  dfpSqrtPkg::dfpWord inData,
	output logic               outValid,
	output dfpSqrtPkg::dfpWord outData
);
	import dfpSqrtPkg::*;

	// dispatcher to lanes
	logic [NUM_LANES-1:0] startLane;
	logic [NUM_LANES-1:0] laneBusy;
	logic [47:0] radicand;
	logic [6:0] resExp;
	sqrtClass resClass;

	// lanes to collector
	logic [NUM_LANES-1:0] laneDone;
	logic [23:0] laneRoot [NUM_LANES];
	logic [6:0] laneExp [NUM_LANES];
	sqrtClass laneClass [NUM_LANES];

	dfpSqrtDispatch dfpSqrtDispatch_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.startLane(startLane),
		.radicand(radicand),
		.resExp(resExp),
		.resClass(resClass),
		.laneBusy(laneBusy)
	);

	// ------------------------------------------------------------------
	// lanes share the dispatcher outputs, each with its own start
	// ------------------------------------------------------------------
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : gLane
		dfpSqrtLane dfpSqrtLane_i (
			.clk(clk),
			.rstN(rstN),
			.start(startLane[i]),
			.radicand(radicand),
			.resExp(resExp),
			.resClass(resClass),
			.busy(laneBusy[i]),
			.done(laneDone[i]),
			.root(laneRoot[i]),
			.rootExp(laneExp[i]),
			.rootClass(laneClass[i])
		);
	end

	dfpSqrtCollect dfpSqrtCollect_i (
		.clk(clk),
		.rstN(rstN),
		.laneDone(laneDone),
		.laneRoot(laneRoot),
		.laneExp(laneExp),
		.laneClass(laneClass),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the decimal square-root testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=dfpSqrtSim

verilator --binary --timing --assert -j 0 \
	--top-module dfpSqrtTb \
	-f tb.f \
	--Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0

// ==== tb.f ====
hw/dfpSqrtPkg.sv
hw/dfpSqrtDispatch.sv
hw/dfpSqrtLane.sv
hw/dfpSqrtCollect.sv
hw/dfpSqrtTop.sv
tb/dfpSqrtTb.sv

// ==== tb/dfpSqrtTb.sv ====
// self-checking testbench for the decimal square-root unit; compile with tb.f and run as top
`timescale 1ns/100ps
`default_nettype none

module dfpSqrtTb;
	import dfpSqrtPkg::*;

	logic clk;
	logic rstN;
	logic inValid;
	dfpWord inData;
	logic outValid;
	dfpWord outData;

	// expected words and their send cycles in issue order
	logic [31:0] expQ [$];
	int sentQ [$];
	int cycleCnt = 0;
	int errors = 0;
	int checks = 0;
	integer seed;

	dfpSqrtTop dfpSqrtTop_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.outValid(outValid),
		.outData(outData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// ------------------------------------------------------------------
	// reference model built from the format rules
	// ------------------------------------------------------------------
	function automatic logic [31:0] refSqrt(input logic [31:0] op);
		logic [31:0] invalidNan;
		logic [23:0] rootBcd;
		longint sigVal;
		longint rad;
		longint lo;
		longint hi;
		longint mid;
		int e;
		int ee;
		int q;
		invalidNan = {1'b0, EXP_ONES, INVALID_SIG};
		// NaN keeps its word, infinity depends on sign
		if (op[30:24] == EXP_ONES)
		begin
			if (op[23:0] != 24'h0)
				return op;
			return op[31] ? invalidNan : op;
		end
		if (op[23:0] == 24'h0)
			return op;
		if (op[31])
			return invalidNan;
		sigVal = 0;
		for (int i = 5; i >= 0; i--)
			sigVal = sigVal * 10 + longint'(op[4*i+:4]);
		e = int'(op[30:24]) - int'(EXP_BIAS);
		// even exponent takes six extra digits, odd takes five
		rad = (e % 2 == 0) ? sigVal * 1000000 : sigVal * 100000;
		// largest r with r*r <= rad
		lo = 0;
		hi = 1000000;
		while (lo < hi)
		begin
			mid = (lo + hi + 1) / 2;
			if (mid * mid <= rad)
				lo = mid;
			else
				hi = mid - 1;
		end
		// integer division truncates toward zero, so negative odd values step down for the floor
		ee = e - 5;
		q = ee / 2;
		if (ee < 0 && ee % 2 != 0)
			q = q - 1;
		for (int i = 0; i < 6; i++)
		begin
			rootBcd[4*i+:4] = 4'(lo % 10);
			lo = lo / 10;
		end
		return {1'b0, 7'(q + int'(EXP_BIAS)), rootBcd};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("FAILED: %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	// one strobe, then idle so strobes land exactly ISSUE_GAP apart
	task automatic sendOperand(input logic [31:0] op);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		inData = op;
		expQ.push_back(refSqrt(op));
		sentQ.push_back(cycleCnt);
		@(posedge clk);
		#1;
		inValid = 1'b0;
		repeat (ISSUE_GAP - 2) @(posedge clk);
	endtask

	function automatic logic [31:0] randomFinite();
		logic [23:0] sig;
		logic [6:0] expF;
		expF = 7'($unsigned($random(seed)) % 127);
		for (int i = 0; i < 6; i++)
			sig[4*i+:4] = 4'($unsigned($random(seed)) % 10);
		if (sig == 24'h0)
			sig = 24'h000001;
		return {1'b0, expF, sig};
	endfunction

	// ------------------------------------------------------------------
	// compare process sampling outputs mid-cycle
	// ------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (outValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				errors++;
				$display("ERROR: outValid rose with no operand pending at %0t", $time);
			end
			else
			begin
				checkValue("outData", outData, expQ.pop_front());
				// latency counted from the cycle that carried the strobe
				checkValue("latency", 32'(cycleCnt - sentQ.pop_front()), 32'(TOTAL_LAT));
			end
		end
		else if (outValid !== 1'b0 && rstN)
		begin
			errors++;
			$display("ERROR: outValid is unknown at %0t", $time);
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial
	begin
		int waitCnt;
		seed = 32'he56f4731;
		rstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;

		// squares and near squares with even and odd exponents
		sendOperand({1'b0, 7'd63, 24'h000004});
		sendOperand({1'b0, 7'd64, 24'h000009});
		sendOperand({1'b0, 7'd61, 24'h000144});
		sendOperand({1'b0, 7'd65, 24'h000049});
		sendOperand({1'b0, 7'd63, 24'h999999});
		// NaN of both signs, +inf, zeros of both signs
		sendOperand({1'b0, 7'd127, 24'h000123});
		sendOperand({1'b1, 7'd127, 24'h000042});
		sendOperand({1'b0, 7'd127, 24'h000000});
		sendOperand({1'b0, 7'd63, 24'h000000});
		sendOperand({1'b1, 7'd20, 24'h000000});
		// invalid operations
		sendOperand({1'b1, 7'd127, 24'h000000});
		sendOperand({1'b1, 7'd63, 24'h000016});
		sendOperand({1'b1, 7'd5, 24'h987654});

		for (int n = 0; n < 24; n++)
			sendOperand(randomFinite());

		// drain what is still in flight
		waitCnt = 0;
		while (expQ.size() != 0 && waitCnt < 2 * TOTAL_LAT)
		begin
			@(posedge clk);
			waitCnt++;
		end
		if (expQ.size() != 0)
		begin
			errors++;
			$display("ERROR: timed out with %0d results never delivered", expQ.size());
		end
		// stray strobes would show up here
		repeat (ISSUE_GAP) @(posedge clk);

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
